// File: common/armCtrl_config.svh
`ifndef ARMCTRL_CONFIG_SVH
`define ARMCTRL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Instruction word
////////////////////////////////////////////////////////////////////////////

`define INSTR_WIDTH 32 // One word sampled per clock

// Opcode field, widest form is the 11-bit R format
`define OP_MSB 31
`define OP_LSB 21

////////////////////////////////////////////////////////////////////////////
// Datapath fields
////////////////////////////////////////////////////////////////////////////

`define REG_ADDR_WIDTH 5 // 32 registers

// ALU function select
`define FS_WIDTH 5

// Immediate after zero extension
`define CONST_WIDTH 64

// Memory access length code
`define LEN_WIDTH 3

`endif

// File: common/armCtrlPkg.sv
`include "armCtrl_config.svh"

package armCtrlPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction classes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		opNone, // Unknown opcode
		// Arithmetic
		opAdd,
		opSub,
		opAddi,
		opSubi,
		opAdds,
		opSubs,
		opAddis,
		opSubis,
		// Data transfer
		opStur, // 64-bit
		opLdur,
		opSturw, // 32-bit
		opLdurw,
		opSturh, // 16-bit
		opLdurh,
		opSturb, // 8-bit
		opLdurb,
		opMovz,
		opMovk,
		// Logic and shifts
		opAnd,
		opOrr,
		opEor,
		opAndi,
		opOrri,
		opEori,
		opAnds,
		opAndis,
		opLsr,
		opLsl,
		// Branches
		opCbz,
		opCbnz,
		opBcond,
		opB,
		opBr,
		opBl
	} opClassE;

	// ALU function select codes
	typedef enum logic [`FS_WIDTH-1:0] {
		fsAdd  = 5'b00010,
		fsSub  = 5'b00110,
		fsPass = 5'b01001, // Pass operand A through
		fsAnd  = 5'b01100,
		fsOr   = 5'b01101,
		fsXor  = 5'b01110,
		fsShl  = 5'b01111,
		fsShr  = 5'b10000
	} funcSelE;

	// Memory access length
	typedef enum logic [`LEN_WIDTH-1:0] {
		len8  = 3'b000,
		len16 = 3'b001,
		len32 = 3'b010,
		len64 = 3'b100
	} accessLenE;

	// Datapath control word, 32 bits, MSB first
	typedef struct packed {
		logic [1:0]                 pcMode;   // PC update mode
		logic [`REG_ADDR_WIDTH-1:0] destReg;  // Write address
		logic [`REG_ADDR_WIDTH-1:0] srcRegA;
		logic [`REG_ADDR_WIDTH-1:0] srcRegB;
		funcSelE                    funcSel;
		logic                       regWrite; // Register file write
		logic                       ramWrite; // Data memory write
		logic                       enMem;    // Memory drives the bus
		logic                       enAlu;    // ALU drives the bus
		logic                       enB;
		logic                       enPc;
		logic                       selConst; // B operand from constant
		logic                       pcSel;    // Branch target select
		logic                       sl;
		logic                       carry;    // Carry in
	} controlWordT;

endpackage

// File: decode/opcodeDecoder.sv
`timescale 1ns/10ps
`include "armCtrl_config.svh"

module opcodeDecoder (
	input  logic [`OP_MSB:`OP_LSB] opField,
	output armCtrlPkg::opClassE    opClass
);

	// Wildcard bits cover the shorter I, D, IW, CB and B formats
	always_comb begin
		priority casez (opField)
			////////////////////////////////////////////////////////////////////////////
			// Arithmetic
			////////////////////////////////////////////////////////////////////////////
			11'b10001011000: opClass = armCtrlPkg::opAdd;
			11'b11001011000: opClass = armCtrlPkg::opSub;
			11'b1001000100?: opClass = armCtrlPkg::opAddi;
			11'b1101000100?: opClass = armCtrlPkg::opSubi;
			11'b10101011000: opClass = armCtrlPkg::opAdds;  // Flag setting
			11'b11101011000: opClass = armCtrlPkg::opSubs;
			11'b1011000100?: opClass = armCtrlPkg::opAddis;
			11'b1111000100?: opClass = armCtrlPkg::opSubis;

			////////////////////////////////////////////////////////////////////////////
			// Data transfer
			////////////////////////////////////////////////////////////////////////////
			// Bit 22 splits load from store
			11'b11111000000: opClass = armCtrlPkg::opStur;
			11'b11111000010: opClass = armCtrlPkg::opLdur;
			11'b10111000000: opClass = armCtrlPkg::opSturw;
			11'b10111000010: opClass = armCtrlPkg::opLdurw;
			11'b01111000000: opClass = armCtrlPkg::opSturh;
			11'b01111000010: opClass = armCtrlPkg::opLdurh;
			11'b00111000000: opClass = armCtrlPkg::opSturb;
			11'b00111000010: opClass = armCtrlPkg::opLdurb;
			11'b110100101??: opClass = armCtrlPkg::opMovz; // Shift amount ignored
			11'b111100101??: opClass = armCtrlPkg::opMovk;

			////////////////////////////////////////////////////////////////////////////
			// Logic and shifts
			////////////////////////////////////////////////////////////////////////////
			11'b10001010000: opClass = armCtrlPkg::opAnd;
			11'b10101010000: opClass = armCtrlPkg::opOrr;
			11'b11001010000: opClass = armCtrlPkg::opEor;
			11'b1001001000?: opClass = armCtrlPkg::opAndi;
			11'b1011001000?: opClass = armCtrlPkg::opOrri;
			11'b1101001000?: opClass = armCtrlPkg::opEori;
			11'b11101010000: opClass = armCtrlPkg::opAnds;
			11'b1111001000?: opClass = armCtrlPkg::opAndis;
			11'b11010011010: opClass = armCtrlPkg::opLsr;
			11'b11010011011: opClass = armCtrlPkg::opLsl;

			////////////////////////////////////////////////////////////////////////////
			// Branches
			////////////////////////////////////////////////////////////////////////////
			11'b10110100???: opClass = armCtrlPkg::opCbz;
			11'b10110101???: opClass = armCtrlPkg::opCbnz;
			11'b01010100???: opClass = armCtrlPkg::opBcond; // Condition in Rt field
			11'b000101?????: opClass = armCtrlPkg::opB;     // 26-bit offset
			11'b11010110000: opClass = armCtrlPkg::opBr;
			11'b100101?????: opClass = armCtrlPkg::opBl;

			default:         opClass = armCtrlPkg::opNone; // Zero control word later
		endcase
	end

endmodule

// File: decode/controlWordBuilder.sv
`timescale 1ns/10ps
`include "armCtrl_config.svh"

module controlWordBuilder (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`INSTR_WIDTH-1:0] instruction,
	input  armCtrlPkg::opClassE     opClass,
	output armCtrlPkg::controlWordT controlWord,
	output armCtrlPkg::accessLenE   length,
	output logic                    flag
);

	armCtrlPkg::controlWordT cwNext;
	armCtrlPkg::accessLenE   lenNext;
	logic                    flagNext;
	logic                    useDest; // Register fields taken for this class
	logic                    useSrcA;
	logic                    useSrcB;

	////////////////////////////////////////////////////////////////////////////
	// Enables and register field usage
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cwNext  = '0; // Unknown opcode stays all zero
		useDest = 1'b0;
		useSrcA = 1'b0;
		useSrcB = 1'b0;

		case (opClass)
			armCtrlPkg::opAdd, armCtrlPkg::opSub, armCtrlPkg::opAdds, armCtrlPkg::opSubs,
			armCtrlPkg::opAnd, armCtrlPkg::opOrr, armCtrlPkg::opEor, armCtrlPkg::opAnds,
			armCtrlPkg::opLsr, armCtrlPkg::opLsl: begin
				cwNext.regWrite = 1'b1;
				cwNext.enAlu    = 1'b1;
				useDest         = 1'b1;
				useSrcA         = 1'b1;
				useSrcB         = 1'b1;
			end
			armCtrlPkg::opAddi, armCtrlPkg::opSubi, armCtrlPkg::opAddis, armCtrlPkg::opSubis,
			armCtrlPkg::opAndi, armCtrlPkg::opOrri, armCtrlPkg::opEori,
			armCtrlPkg::opAndis: begin
				cwNext.regWrite = 1'b1;
				cwNext.enAlu    = 1'b1;
				cwNext.selConst = 1'b1; // Immediate replaces Rm
				useDest         = 1'b1;
				useSrcA         = 1'b1;
			end
			armCtrlPkg::opStur, armCtrlPkg::opSturw, armCtrlPkg::opSturh,
			armCtrlPkg::opSturb: begin
				cwNext.ramWrite = 1'b1;
				cwNext.enAlu    = 1'b1; // Store data over the ALU path
				cwNext.selConst = 1'b1; // Base plus offset
				useDest         = 1'b1;
				useSrcA         = 1'b1;
			end
			armCtrlPkg::opLdur, armCtrlPkg::opLdurw, armCtrlPkg::opLdurh,
			armCtrlPkg::opLdurb: begin
				cwNext.regWrite = 1'b1;
				cwNext.enMem    = 1'b1;
				cwNext.selConst = 1'b1;
				useDest         = 1'b1;
				useSrcA         = 1'b1;
			end
			armCtrlPkg::opMovz: begin
				cwNext.regWrite = 1'b1;
				cwNext.enAlu    = 1'b1;
				cwNext.selConst = 1'b1;
				useDest         = 1'b1;
			end
			armCtrlPkg::opMovk: begin // Memory enable in place of the ALU
				cwNext.regWrite = 1'b1;
				cwNext.enMem    = 1'b1;
				cwNext.selConst = 1'b1;
				useDest         = 1'b1;
			end
			armCtrlPkg::opCbz: begin
				cwNext.enAlu = 1'b1;
				cwNext.pcSel = 1'b1;
				useDest      = 1'b1; // Rt is the tested register
			end
			armCtrlPkg::opCbnz, armCtrlPkg::opBcond: begin
				cwNext.regWrite = 1'b1;
				cwNext.enAlu    = 1'b1;
				cwNext.pcSel    = 1'b1;
				useDest         = 1'b1;
			end
			armCtrlPkg::opB, armCtrlPkg::opBl: begin
				cwNext.regWrite = 1'b1;
				cwNext.enAlu    = 1'b1;
				cwNext.pcSel    = 1'b1;
			end
			armCtrlPkg::opBr: begin
				cwNext.enAlu = 1'b1;
				useDest      = 1'b1;
				useSrcA      = 1'b1;
				useSrcB      = 1'b1;
			end
			default: ;
		endcase

		// ALU operation
		case (opClass)
			armCtrlPkg::opSub, armCtrlPkg::opSubs, armCtrlPkg::opSubi,
			armCtrlPkg::opSubis: cwNext.funcSel = armCtrlPkg::fsSub;
			armCtrlPkg::opAnd, armCtrlPkg::opAnds, armCtrlPkg::opAndi, armCtrlPkg::opAndis,
			armCtrlPkg::opCbz, armCtrlPkg::opCbnz, armCtrlPkg::opBcond,
			armCtrlPkg::opB, armCtrlPkg::opBl: cwNext.funcSel = armCtrlPkg::fsAnd;
			armCtrlPkg::opOrr, armCtrlPkg::opOrri,
			armCtrlPkg::opMovz: cwNext.funcSel = armCtrlPkg::fsOr;
			armCtrlPkg::opEor, armCtrlPkg::opEori: cwNext.funcSel = armCtrlPkg::fsXor;
			armCtrlPkg::opLsl:  cwNext.funcSel = armCtrlPkg::fsShl;
			armCtrlPkg::opLsr:  cwNext.funcSel = armCtrlPkg::fsShr;
			armCtrlPkg::opBr:   cwNext.funcSel = armCtrlPkg::fsPass;
			armCtrlPkg::opNone: ; // Keeps zero
			default:            cwNext.funcSel = armCtrlPkg::fsAdd; // Adds, memory, MOVK
		endcase

		// Common to every known class
		if (opClass != armCtrlPkg::opNone) begin
			cwNext.sl     = 1'b1;
			cwNext.pcMode = (opClass == armCtrlPkg::opStur || opClass == armCtrlPkg::opLdur)
				? 2'b00 : 2'b01; // 64-bit transfers hold the PC mode at 00
		end

		// Unused fields read as zero
		cwNext.destReg = useDest ? instruction[4:0] : '0;   // Rd / Rt
		cwNext.srcRegA = useSrcA ? instruction[9:5] : '0;   // Rn
		cwNext.srcRegB = useSrcB ? instruction[20:16] : '0; // Rm
	end

	////////////////////////////////////////////////////////////////////////////
	// Access length and flag set
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (opClass)
			armCtrlPkg::opStur, armCtrlPkg::opLdur:   lenNext = armCtrlPkg::len64;
			armCtrlPkg::opSturh, armCtrlPkg::opLdurh: lenNext = armCtrlPkg::len16;
			armCtrlPkg::opSturb, armCtrlPkg::opLdurb,
			armCtrlPkg::opNone:                       lenNext = armCtrlPkg::len8;
			default:                                  lenNext = armCtrlPkg::len32;
		endcase

		flagNext = (opClass == armCtrlPkg::opAdds) || (opClass == armCtrlPkg::opSubs)
			|| (opClass == armCtrlPkg::opAddis) || (opClass == armCtrlPkg::opSubis)
			|| (opClass == armCtrlPkg::opAnds) || (opClass == armCtrlPkg::opAndis);
	end

	// One cycle of latency
	always_ff @(posedge clk) begin
		if (rst) begin
			controlWord <= '0;
			length      <= armCtrlPkg::len8; // Code 000
			flag        <= 1'b0;
		end else begin
			controlWord <= cwNext;
			length      <= lenNext;
			flag        <= flagNext;
		end
	end

endmodule

// File: logic/immediateGen.sv
`timescale 1ns/10ps
`include "armCtrl_config.svh"

module immediateGen (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`INSTR_WIDTH-1:0] instruction,
	input  armCtrlPkg::opClassE     opClass,
	output logic [`CONST_WIDTH-1:0] constant
);

	logic [`CONST_WIDTH-1:0] constNext; // Zero extended immediate

	////////////////////////////////////////////////////////////////////////////
	// Field select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		constNext = '0; // No immediate
		case (opClass)
			armCtrlPkg::opAddi, armCtrlPkg::opSubi, armCtrlPkg::opAddis, armCtrlPkg::opSubis,
			armCtrlPkg::opAndi, armCtrlPkg::opOrri, armCtrlPkg::opEori,
			armCtrlPkg::opAndis:
				constNext[11:0] = instruction[21:10]; // ALU_immediate
			armCtrlPkg::opStur, armCtrlPkg::opLdur, armCtrlPkg::opSturw, armCtrlPkg::opLdurw,
			armCtrlPkg::opSturh, armCtrlPkg::opLdurh, armCtrlPkg::opSturb,
			armCtrlPkg::opLdurb:
				constNext[8:0] = instruction[20:12]; // DT_address
			armCtrlPkg::opMovz, armCtrlPkg::opMovk:
				constNext[15:0] = instruction[20:5]; // MOV_immediate, shift not applied
			armCtrlPkg::opCbz, armCtrlPkg::opCbnz, armCtrlPkg::opBcond:
				constNext[21:2] = instruction[24:5]; // Word offset to bytes
			armCtrlPkg::opB, armCtrlPkg::opBl:
				constNext[27:2] = instruction[25:0]; // Unsigned, no sign extension
			default: ;
		endcase
	end

	// Registered alongside the control word
	always_ff @(posedge clk) begin
		if (rst) begin
			constant <= '0;
		end else begin
			constant <= constNext;
		end
	end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/10ps
`include "armCtrl_config.svh"

module controlUnit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`INSTR_WIDTH-1:0] instruction,
	output armCtrlPkg::controlWordT controlWord,
	output logic [`CONST_WIDTH-1:0] constant,
	output armCtrlPkg::accessLenE   length,
	output logic                    flag
);

	armCtrlPkg::opClassE opClass; // Decoded class, same cycle as instruction

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	// Combinational opcode match
	opcodeDecoder decoder (
		.opField (instruction[`OP_MSB:`OP_LSB]),
		.opClass (opClass)
	);

	////////////////////////////////////////////////////////////////////////////
	// Registered outputs
	////////////////////////////////////////////////////////////////////////////

	// Control word, length and flag
	controlWordBuilder cwBuilder (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.opClass     (opClass),
		.controlWord (controlWord),
		.length      (length),
		.flag        (flag)
	);

	// Immediate constant, same latency
	immediateGen immGen (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.opClass     (opClass),
		.constant    (constant)
	);

endmodule

// File: tests/decodeTable.svh
`ifndef DECODE_TABLE_SVH
`define DECODE_TABLE_SVH

// Columns: name, opcode, wildcard mask, funcSel, pcMode,
// enables {regWrite ramWrite enMem enAlu selConst pcSel sl}, regs {dest srcA srcB},
// immediate kind (0 none, 1 bits 21..10, 2 bits 20..12, 3 bits 20..5,
// 4 bits 24..5 x4, 5 bits 25..0 x4), length code, flag
task automatic loadTable();
	////////////////////////////////////////////////////////////////////////////
	// Arithmetic
	////////////////////////////////////////////////////////////////////////////
	addRow("ADD", 11'b10001011000, 11'h000, 5'b00010, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	addRow("SUB", 11'b11001011000, 11'h000, 5'b00110, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	addRow("ADDI", 11'b10010001000, 11'h001, 5'b00010, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 0);
	addRow("SUBI", 11'b11010001000, 11'h001, 5'b00110, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 0);
	addRow("ADDS", 11'b10101011000, 11'h000, 5'b00010, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 1);
	addRow("SUBS", 11'b11101011000, 11'h000, 5'b00110, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 1);
	addRow("ADDIS", 11'b10110001000, 11'h001, 5'b00010, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 1);
	addRow("SUBIS", 11'b11110001000, 11'h001, 5'b00110, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 1);
	////////////////////////////////////////////////////////////////////////////
	// Data transfer, 64-bit forms keep pcMode 00
	////////////////////////////////////////////////////////////////////////////
	addRow("STUR", 11'b11111000000, 11'h000, 5'b00010, 2'b00, 7'b0101101, 3'b110, 2, 3'b100, 0);
	addRow("LDUR", 11'b11111000010, 11'h000, 5'b00010, 2'b00, 7'b1010101, 3'b110, 2, 3'b100, 0);
	addRow("STURW", 11'b10111000000, 11'h000, 5'b00010, 2'b01, 7'b0101101, 3'b110, 2, 3'b010, 0);
	addRow("LDURW", 11'b10111000010, 11'h000, 5'b00010, 2'b01, 7'b1010101, 3'b110, 2, 3'b010, 0);
	addRow("STURH", 11'b01111000000, 11'h000, 5'b00010, 2'b01, 7'b0101101, 3'b110, 2, 3'b001, 0);
	addRow("LDURH", 11'b01111000010, 11'h000, 5'b00010, 2'b01, 7'b1010101, 3'b110, 2, 3'b001, 0);
	addRow("STURB", 11'b00111000000, 11'h000, 5'b00010, 2'b01, 7'b0101101, 3'b110, 2, 3'b000, 0);
	addRow("LDURB", 11'b00111000010, 11'h000, 5'b00010, 2'b01, 7'b1010101, 3'b110, 2, 3'b000, 0);
	addRow("MOVZ", 11'b11010010100, 11'h003, 5'b01101, 2'b01, 7'b1001101, 3'b100, 3, 3'b010, 0);
	addRow("MOVK", 11'b11110010100, 11'h003, 5'b00010, 2'b01, 7'b1010101, 3'b100, 3, 3'b010, 0);
	////////////////////////////////////////////////////////////////////////////
	// Logic and shifts
	////////////////////////////////////////////////////////////////////////////
	addRow("AND", 11'b10001010000, 11'h000, 5'b01100, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	addRow("ORR", 11'b10101010000, 11'h000, 5'b01101, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	addRow("EOR", 11'b11001010000, 11'h000, 5'b01110, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	addRow("ANDI", 11'b10010010000, 11'h001, 5'b01100, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 0);
	addRow("ORRI", 11'b10110010000, 11'h001, 5'b01101, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 0);
	addRow("EORI", 11'b11010010000, 11'h001, 5'b01110, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 0);
	addRow("ANDS", 11'b11101010000, 11'h000, 5'b01100, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 1);
	addRow("ANDIS", 11'b11110010000, 11'h001, 5'b01100, 2'b01, 7'b1001101, 3'b110, 1, 3'b010, 1);
	addRow("LSR", 11'b11010011010, 11'h000, 5'b10000, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	addRow("LSL", 11'b11010011011, 11'h000, 5'b01111, 2'b01, 7'b1001001, 3'b111, 0, 3'b010, 0);
	////////////////////////////////////////////////////////////////////////////
	// Branches, then the unknown opcode
	////////////////////////////////////////////////////////////////////////////
	addRow("CBZ", 11'b10110100000, 11'h007, 5'b01100, 2'b01, 7'b0001011, 3'b100, 4, 3'b010, 0);
	addRow("CBNZ", 11'b10110101000, 11'h007, 5'b01100, 2'b01, 7'b1001011, 3'b100, 4, 3'b010, 0);
	addRow("BCOND", 11'b01010100000, 11'h007, 5'b01100, 2'b01, 7'b1001011, 3'b100, 4, 3'b010, 0);
	addRow("B", 11'b00010100000, 11'h01F, 5'b01100, 2'b01, 7'b1001011, 3'b000, 5, 3'b010, 0);
	addRow("BR", 11'b11010110000, 11'h000, 5'b01001, 2'b01, 7'b0001001, 3'b111, 0, 3'b010, 0);
	addRow("BL", 11'b10010100000, 11'h01F, 5'b01100, 2'b01, 7'b1001011, 3'b000, 5, 3'b010, 0);
	addRow("UNKNOWN", 11'b00000000000, 11'h000, 5'b00000, 2'b00, 7'b0000000, 3'b000, 0, 3'b000, 0);
endtask

`endif

// File: tests/controlUnitTb.sv
`timescale 1ns/10ps
`include "armCtrl_config.svh"

module controlUnitTb;

	localparam int OP_WIDTH      = `OP_MSB - `OP_LSB + 1;
	localparam int RESET_TIMEOUT = 20; // Cycles

	// Expected class attributes for one opcode pattern
	typedef struct packed {
		logic [63:0]         name;     // Up to 8 ASCII characters
		logic [OP_WIDTH-1:0] opcode;
		logic [OP_WIDTH-1:0] freeMask; // Wildcard opcode bits
		logic [4:0]          fsCode;
		logic [1:0]          pcMode;
		logic [6:0]          enables;
		logic [2:0]          regUse;   // Dest, srcA, srcB
		logic [2:0]          immKind;
		logic [2:0]          lenCode;
		logic                flag;
	} rowT;

	logic                    clk;
	logic                    rst;
	logic [`INSTR_WIDTH-1:0] instruction;
	armCtrlPkg::controlWordT controlWord;
	logic [`CONST_WIDTH-1:0] constant;
	armCtrlPkg::accessLenE   length;
	logic                    flag;

	rowT                     decodeRows[$];
	logic [`INSTR_WIDTH-1:0] sentInstr[$]; // Words in order of issue
	logic [15:0]             lfsrState;
	int                      errorCount;
	int                      testCount;
	int                      failedTests;
	logic                    rowBad;
	logic                    timedOut;

	controlUnit dut (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.controlWord (controlWord),
		.constant    (constant),
		.length      (length),
		.flag        (flag)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	task automatic addRow(input logic [63:0] name, input logic [OP_WIDTH-1:0] opcode,
		input logic [OP_WIDTH-1:0] freeMask, input logic [4:0] fsCode, input logic [1:0] pcMode,
		input logic [6:0] enables, input logic [2:0] regUse, input int immKind,
		input logic [2:0] lenCode, input logic flag);
		decodeRows.push_back({name, opcode, freeMask, fsCode, pcMode, enables, regUse,
			3'(immKind), lenCode, flag});
	endtask

	`include "decodeTable.svh"

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and expected values
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic randomBit();
		logic feedback;
		feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], feedback};
		return feedback;
	endfunction

	// Fixed opcode bits, random fields and wildcards
	function automatic logic [`INSTR_WIDTH-1:0] buildInstr(input rowT r);
		logic [`INSTR_WIDTH-1:0] word;
		word                     = '0;
		word[`OP_MSB:`OP_LSB]    = r.opcode;
		for (int b = 0; b < `INSTR_WIDTH; b++) begin
			if (b < `OP_LSB)
				word[b] = randomBit();
			else if (r.freeMask[b - `OP_LSB])
				word[b] = randomBit();
		end
		return word;
	endfunction

	function automatic armCtrlPkg::controlWordT expectedWord(input rowT r,
		input logic [`INSTR_WIDTH-1:0] word);
		armCtrlPkg::controlWordT cw;
		cw         = '0; // enB, enPc and carry stay low
		cw.pcMode  = r.pcMode;
		cw.destReg = r.regUse[2] ? word[4:0] : '0;
		cw.srcRegA = r.regUse[1] ? word[9:5] : '0;
		cw.srcRegB = r.regUse[0] ? word[20:16] : '0;
		cw.funcSel = armCtrlPkg::funcSelE'(r.fsCode);
		{cw.regWrite, cw.ramWrite, cw.enMem, cw.enAlu, cw.selConst, cw.pcSel, cw.sl} = r.enables;
		return cw;
	endfunction

	function automatic logic [`CONST_WIDTH-1:0] expectedConst(input rowT r,
		input logic [`INSTR_WIDTH-1:0] word);
		logic [`CONST_WIDTH-1:0] value;
		case (r.immKind)
			3'd1:    value = `CONST_WIDTH'(word[21:10]);
			3'd2:    value = `CONST_WIDTH'(word[20:12]);
			3'd3:    value = `CONST_WIDTH'(word[20:5]);
			3'd4:    value = `CONST_WIDTH'({word[24:5], 2'b00}); // Offset in bytes
			3'd5:    value = `CONST_WIDTH'({word[25:0], 2'b00});
			default: value = '0;
		endcase
		return value;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkWord(input armCtrlPkg::controlWordT expWord,
		input armCtrlPkg::controlWordT gotWord);
		if (gotWord !== expWord) begin
			$display("ERR t=%0t controlWord expected %h got %h", $time, expWord, gotWord);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic checkConst(input logic [`CONST_WIDTH-1:0] expConst,
		input logic [`CONST_WIDTH-1:0] gotConst);
		if (gotConst !== expConst) begin
			$display("ERR t=%0t constant expected %h got %h", $time, expConst, gotConst);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic checkLen(input armCtrlPkg::accessLenE expLen,
		input armCtrlPkg::accessLenE gotLen);
		if (gotLen !== expLen) begin
			$display("ERR t=%0t length expected %b got %b", $time, expLen, gotLen);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic checkFlag(input logic expFlag, input logic gotFlag);
		if (gotFlag !== expFlag) begin
			$display("ERR t=%0t flag expected %b got %b", $time, expFlag, gotFlag);
			errorCount++;
			rowBad = 1'b1;
		end
	endtask

	task automatic reportTest(input logic [63:0] name);
		testCount++;
		if (rowBad) begin
			failedTests++;
			$display("test %0d %0s failed", testCount, name);
		end else begin
			$display("test %0d %0s ok", testCount, name);
		end
		rowBad = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [`INSTR_WIDTH-1:0] word;
		int                      waitCount;
		lfsrState   = 16'd70;
		errorCount  = 0;
		testCount   = 0;
		failedTests = 0;
		rowBad      = 1'b0;
		timedOut    = 1'b0;
		rst         = 1'b1;
		loadTable();
		instruction = buildInstr(decodeRows[0]); // Decodable word held through reset

		repeat (2) @(posedge clk);
		rst       <= 1'b0;
		waitCount = 0;
		while (rst !== 1'b0 && waitCount < RESET_TIMEOUT) begin
			@(negedge clk); // Outputs settled mid cycle
			waitCount++;
		end

		if (rst !== 1'b0) begin
			timedOut = 1'b1;
			$display("Timeout: reset still high after %0d cycles", RESET_TIMEOUT);
		end else begin
			// Still the values from the last reset edge
			checkWord('0, controlWord);
			checkConst('0, constant);
			checkLen(armCtrlPkg::len8, length);
			checkFlag(1'b0, flag);
			reportTest("reset");

			// One word per edge and each checked one cycle later
			for (int i = 0; i <= decodeRows.size(); i++) begin
				@(posedge clk);
				if (i < decodeRows.size()) begin
					word = buildInstr(decodeRows[i]);
					sentInstr.push_back(word);
					instruction <= word;
				end
				@(negedge clk);
				if (i > 0) begin
					checkWord(expectedWord(decodeRows[i-1], sentInstr[i-1]), controlWord);
					checkConst(expectedConst(decodeRows[i-1], sentInstr[i-1]), constant);
					checkLen(armCtrlPkg::accessLenE'(decodeRows[i-1].lenCode), length);
					checkFlag(decodeRows[i-1].flag, flag);
					reportTest(decodeRows[i-1].name);
				end
			end
		end

		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0 && !timedOut)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: Makefile
# Verilator build and run of the control unit testbench

VERILATOR  ?= verilator
TOP        ?= controlUnitTb
DUT_TOP    ?= controlUnit
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
+incdir+common
+incdir+tests
common/armCtrlPkg.sv
decode/opcodeDecoder.sv
decode/controlWordBuilder.sv
logic/immediateGen.sv
logic/controlUnit.sv
tests/controlUnitTb.sv
